/* source/audio_pkg.sv */
`default_nettype none

package audio_pkg;

  ////////////////////////////////////////////////////////////
  // frame geometry and timing
  ////////////////////////////////////////////////////////////

  localparam int FRAME_BITS      = 256;
  localparam int BIT_COUNT_WIDTH = $clog2(FRAME_BITS);  // 8
  typedef logic [BIT_COUNT_WIDTH-1:0] bit_count_t;

  localparam bit_count_t SYNC_LAST_BIT   = 8'd15;
  localparam bit_count_t CREDIT_BIT      = 8'd128;   // one credit per frame
  localparam bit_count_t FRAME_LATCH_BIT = 8'd255;   // latch + frame boundary
  localparam bit_count_t RX_DONE_BIT     = 8'd97;    // left sample to filter

  // slot positions, slot 0 is the tag
  localparam bit_count_t SLOT_CMD_ADDR_FIRST = 8'd16;
  localparam bit_count_t SLOT_CMD_DATA_FIRST = 8'd36;
  localparam bit_count_t SLOT_LEFT_FIRST     = 8'd56;
  localparam bit_count_t SLOT_RIGHT_FIRST    = 8'd76;
  localparam int         SLOT_BITS           = 20;
  localparam int         SLOT_INDEX_WIDTH    = $clog2(SLOT_BITS);

  ////////////////////////////////////////////////////////////
  // widths and types
  ////////////////////////////////////////////////////////////

  localparam int PCM_BITS   = 8;
  localparam int COEFF_BITS = 10;
  localparam int ACC_BITS   = PCM_BITS + COEFF_BITS;     // 18

  typedef logic        [SLOT_BITS-1:0]        slot_word_t;
  typedef logic        [SLOT_INDEX_WIDTH-1:0] slot_index_t;
  typedef logic signed [PCM_BITS-1:0]         pcm_sample_t;
  typedef logic signed [ACC_BITS-1:0]         filter_acc_t;
  typedef logic signed [COEFF_BITS-1:0]       coeff_t;
  typedef logic        [7:0]                  cmd_addr_t;
  typedef logic        [15:0]                 cmd_data_t;
  typedef logic        [4:0]                  volume_t;

  localparam volume_t VOLUME_MAX   = 5'd31;  // loudest
  localparam volume_t VOLUME_RESET = 5'd8;

  // codec reset delay and button debounce
  localparam int CODEC_RESET_CYCLES   = 1023;
  localparam int RESET_COUNT_WIDTH    = $clog2(CODEC_RESET_CYCLES);
  localparam int DEBOUNCE_CYCLES      = 64;  // short enough to simulate
  localparam int DEBOUNCE_COUNT_WIDTH = $clog2(DEBOUNCE_CYCLES + 1);

  ////////////////////////////////////////////////////////////
  // low-pass filter, round(fir1(30,.125)*1024)
  ////////////////////////////////////////////////////////////

  localparam int FIR_TAPS          = 31;
  localparam int FIR_INDEX_WIDTH   = $clog2(FIR_TAPS);
  localparam int HISTORY_DEPTH     = 32;
  localparam int HISTORY_PTR_WIDTH = $clog2(HISTORY_DEPTH);
  localparam int FIR_SHIFT         = 10;  // coefficients scaled by 2**10

  localparam coeff_t FIR_COEFFS [FIR_TAPS] = '{
    -10'sd1,  -10'sd1,  -10'sd3,  -10'sd5,  -10'sd6,  -10'sd7,  -10'sd5,  10'sd0,
     10'sd10,  10'sd26,  10'sd46,  10'sd69,  10'sd91,  10'sd110, 10'sd123, 10'sd128,
     10'sd123, 10'sd110, 10'sd91,  10'sd69,  10'sd46,  10'sd26,  10'sd10,  10'sd0,
    -10'sd5,  -10'sd7,  -10'sd6,  -10'sd5,  -10'sd3,  -10'sd1,  -10'sd1
  };  // sum 1022

  // codec registers
  localparam cmd_addr_t REG_READ_ID       = 8'h80;
  localparam cmd_addr_t REG_HEADPHONE_VOL = 8'h04;
  localparam cmd_addr_t REG_PCM_VOL       = 8'h18;
  localparam cmd_addr_t REG_RECORD_SELECT = 8'h1A;
  localparam cmd_addr_t REG_RECORD_GAIN   = 8'h1C;
  localparam cmd_addr_t REG_MIC_GAIN      = 8'h0E;
  localparam cmd_addr_t REG_BEEP_VOL      = 8'h0A;
  localparam cmd_addr_t REG_GENERAL       = 8'h20;

  localparam cmd_data_t  READ_ID_DATA     = 16'h0000;
  localparam cmd_data_t  PCM_VOL_DATA     = 16'h0808;
  localparam logic [2:0] REC_SOURCE_MIC   = 3'd0;
  localparam cmd_data_t  RECORD_GAIN_DATA = 16'h0F0F;  // max gain
  localparam cmd_data_t  MIC_GAIN_DATA    = 16'h8048;  // +20 dB boost
  localparam cmd_data_t  BEEP_VOL_DATA    = 16'h0000;
  localparam cmd_data_t  GENERAL_DATA     = 16'h8000;  // pcm out bypasses mix1

endpackage

`default_nettype wire

/* source/codec_command_if.sv */
`default_nettype none

// register commands from the sequencer, frame boundary from the link
interface codec_command_if
  import audio_pkg::*;
();

  logic      frame_start;  // one cycle, at the latch bit
  cmd_addr_t cmd_address;
  cmd_data_t cmd_data;
  logic      cmd_valid;

  modport link (output frame_start, input cmd_address, cmd_data, cmd_valid);

  modport sequencer (input frame_start, output cmd_address, cmd_data, cmd_valid);

endinterface

`default_nettype wire

/* source/button_debounce.sv */
`default_nettype none

module button_debounce
  import audio_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic noisy,
  output logic clean
);

  logic                            last_level;  // last raw level seen
  logic [DEBOUNCE_COUNT_WIDTH-1:0] stable_count;

  always_ff @(posedge clock) begin
    if (reset) begin
      last_level   <= noisy;
      clean        <= noisy;  // start from whatever the pin shows
      stable_count <= '0;
    end else if (noisy != last_level) begin
      // level moved, start the wait over
      last_level   <= noisy;
      stable_count <= '0;
    end else if (stable_count == DEBOUNCE_COUNT_WIDTH'(DEBOUNCE_CYCLES)) begin
      clean <= last_level;  // stable long enough
    end else begin
      stable_count <= stable_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* source/volume_control.sv */
`default_nettype none

module volume_control
  import audio_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  logic    button_up,
  input  logic    button_down,
  output volume_t volume
);

  logic up_clean, down_clean;
  logic up_prev, down_prev;    // for edge detect

  button_debounce up_debounce (
    .clock (clock),
    .reset (reset),
    .noisy (button_up),
    .clean (up_clean)
  );

  button_debounce down_debounce (
    .clock (clock),
    .reset (reset),
    .noisy (button_down),
    .clean (down_clean)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      volume    <= VOLUME_RESET;
      up_prev   <= up_clean;     // a button held through reset is no press
      down_prev <= down_clean;
    end else begin
      up_prev   <= up_clean;
      down_prev <= down_clean;
      if (up_clean && !up_prev && volume != VOLUME_MAX)
        volume <= volume + 1'b1;   // saturate at the top
      else if (down_clean && !down_prev && volume != '0)
        volume <= volume - 1'b1;   // and at zero
    end
  end

endmodule

`default_nettype wire

/* source/codec_command_sequencer.sv */
`default_nettype none

module codec_command_sequencer
  import audio_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  volume_t volume,
  codec_command_if.sequencer cmd
);

  logic [3:0] state;        // wraps every 16 frames
  volume_t    attenuation;

  assign attenuation = VOLUME_MAX - volume;  // codec wants attenuation, not gain

  always_ff @(posedge clock) begin
    if (reset) begin
      state         <= '0;
      cmd.cmd_valid <= 1'b0;
    end else begin
      if (cmd.frame_start)
        state <= state + 1'b1;
      if (state == 4'h0)
        cmd.cmd_valid <= 1'b1;  // stays high from here on
    end
  end

  // command words follow the state, held until the next frame boundary
  always_ff @(posedge clock) begin
    case (state)
      4'h3: begin
        cmd.cmd_address <= REG_HEADPHONE_VOL;
        cmd.cmd_data    <= {3'b000, attenuation, 3'b000, attenuation};  // left, right
      end
      4'h5: begin
        cmd.cmd_address <= REG_PCM_VOL;
        cmd.cmd_data    <= PCM_VOL_DATA;
      end
      4'h6: begin
        cmd.cmd_address <= REG_RECORD_SELECT;
        cmd.cmd_data    <= {5'b00000, REC_SOURCE_MIC, 5'b00000, REC_SOURCE_MIC};
      end
      4'h7: begin
        cmd.cmd_address <= REG_RECORD_GAIN;
        cmd.cmd_data    <= RECORD_GAIN_DATA;
      end
      4'h9: begin
        cmd.cmd_address <= REG_MIC_GAIN;
        cmd.cmd_data    <= MIC_GAIN_DATA;
      end
      4'hA: begin
        cmd.cmd_address <= REG_BEEP_VOL;
        cmd.cmd_data    <= BEEP_VOL_DATA;
      end
      4'hB: begin
        cmd.cmd_address <= REG_GENERAL;
        cmd.cmd_data    <= GENERAL_DATA;
      end
      default: begin  // states 0, 1 and the idle ones read the ID
        cmd.cmd_address <= REG_READ_ID;
        cmd.cmd_data    <= READ_ID_DATA;
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/ac97_frame_link.sv */
`default_nettype none

module ac97_frame_link
  import audio_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        sdata_in,
  output logic        sdata_out,
  output logic        sync,
  output logic        codec_reset_b,
  codec_command_if.link cmd,
  output pcm_sample_t rx_sample,
  output logic        rx_valid,
  output logic        credit,
  input  pcm_sample_t tx_sample,
  input  logic        tx_valid
);

  bit_count_t                   bit_count;
  logic [RESET_COUNT_WIDTH-1:0] reset_count;

  // words for the frame being sent
  slot_word_t  out_cmd_addr, out_cmd_data, out_pcm;
  logic        out_cmd_valid;
  pcm_sample_t pending_sample;  // last sample from the filter
  slot_word_t  rx_shift;        // slot 3 input

  // one bit of a slot word, msb first
  function automatic logic slot_bit(input slot_word_t word, input bit_count_t first,
                                    input bit_count_t count);
    bit_count_t offset;
    offset = count - first;
    return word[slot_index_t'(SLOT_BITS - 1) - offset[SLOT_INDEX_WIDTH-1:0]];
  endfunction

  assign cmd.frame_start = (bit_count == FRAME_LATCH_BIT);

  ////////////////////////////////////////////////////////////
  // frame timing and codec reset
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      bit_count     <= '0;
      sync          <= 1'b0;
      credit        <= 1'b0;
      reset_count   <= '0;
      codec_reset_b <= 1'b0;
    end else begin
      bit_count <= bit_count + 1'b1;  // wraps at 256
      if (bit_count == FRAME_LATCH_BIT)
        sync <= 1'b1;
      else if (bit_count == SYNC_LAST_BIT)
        sync <= 1'b0;                 // 16 cycles high
      credit <= (bit_count == CREDIT_BIT);
      if (reset_count == RESET_COUNT_WIDTH'(CODEC_RESET_CYCLES - 1))
        codec_reset_b <= 1'b1;        // let the codec come up
      else
        reset_count <= reset_count + 1'b1;
    end
  end

  // filter output waits here, a frame with no new sample repeats it
  always_ff @(posedge clock) begin
    if (reset)
      pending_sample <= '0;
    else if (tx_valid)
      pending_sample <= tx_sample;
  end

  ////////////////////////////////////////////////////////////
  // serializer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      out_cmd_valid <= 1'b0;
    end else if (bit_count == FRAME_LATCH_BIT) begin
      out_cmd_valid <= cmd.cmd_valid;
    end
  end

  // address and data left-justified, zero when no command
  always_ff @(posedge clock) begin
    if (bit_count == FRAME_LATCH_BIT) begin
      out_cmd_addr <= cmd.cmd_valid ? {cmd.cmd_address, 12'h000} : '0;
      out_cmd_data <= cmd.cmd_valid ? {cmd.cmd_data, 4'h0} : '0;
      out_pcm      <= {pending_sample, 12'h000};  // same word left and right
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      sdata_out <= 1'b0;
    end else if (bit_count <= SYNC_LAST_BIT) begin
      case (bit_count[3:0])        // slot 0, tags
        4'h0:    sdata_out <= 1'b1;           // frame valid
        4'h1:    sdata_out <= out_cmd_valid;  // address valid
        4'h2:    sdata_out <= out_cmd_valid;  // data valid
        4'h3:    sdata_out <= 1'b1;           // left valid
        4'h4:    sdata_out <= 1'b1;           // right valid
        default: sdata_out <= 1'b0;
      endcase
    end else if (bit_count < SLOT_CMD_DATA_FIRST) begin
      sdata_out <= slot_bit(out_cmd_addr, SLOT_CMD_ADDR_FIRST, bit_count);
    end else if (bit_count < SLOT_LEFT_FIRST) begin
      sdata_out <= slot_bit(out_cmd_data, SLOT_CMD_DATA_FIRST, bit_count);
    end else if (bit_count < SLOT_RIGHT_FIRST) begin
      sdata_out <= slot_bit(out_pcm, SLOT_LEFT_FIRST, bit_count);
    end else if (bit_count < SLOT_RIGHT_FIRST + bit_count_t'(SLOT_BITS)) begin
      sdata_out <= slot_bit(out_pcm, SLOT_RIGHT_FIRST, bit_count);
    end else begin
      sdata_out <= 1'b0;  // slots 5 to 12 unused
    end
  end

  ////////////////////////////////////////////////////////////
  // left input deserializer
  ////////////////////////////////////////////////////////////

  // codec bits trail our count by one, as sdata_out does
  always_ff @(posedge clock) begin
    if (bit_count > SLOT_LEFT_FIRST &&
        bit_count <= SLOT_LEFT_FIRST + bit_count_t'(SLOT_BITS))
      rx_shift <= {rx_shift[SLOT_BITS-2:0], sdata_in};
    if (bit_count == RX_DONE_BIT)
      rx_sample <= pcm_sample_t'(rx_shift[SLOT_BITS-1 -: PCM_BITS]);  // top 8 bits
  end

  always_ff @(posedge clock) begin
    if (reset)
      rx_valid <= 1'b0;
    else
      rx_valid <= (bit_count == RX_DONE_BIT);
  end

endmodule

`default_nettype wire

/* source/fir_lowpass.sv */
`default_nettype none

module fir_lowpass
  import audio_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        filter_enable,
  input  pcm_sample_t rx_sample,
  input  logic        rx_valid,
  input  logic        credit,
  output pcm_sample_t tx_sample,
  output logic        tx_valid
);

  pcm_sample_t                  history [HISTORY_DEPTH];  // circular, newest at wr_ptr-1
  logic [HISTORY_PTR_WIDTH-1:0] wr_ptr, tap_ptr;
  logic [FIR_INDEX_WIDTH-1:0]   tap_index;
  logic                         busy;
  filter_acc_t                  acc, acc_next, product;
  pcm_sample_t                  result;
  logic                         result_ready;  // finished, not yet sent
  logic                         credit_held;
  logic                         have_credit;

  assign tap_ptr     = wr_ptr - 1'b1 - HISTORY_PTR_WIDTH'(tap_index);  // delay of tap_index
  assign product     = FIR_COEFFS[tap_index] * history[tap_ptr];
  assign acc_next    = acc + product;
  assign have_credit = credit_held | credit;

  always_ff @(posedge clock) begin
    if (rx_valid)
      history[wr_ptr] <= rx_sample;
  end

  ////////////////////////////////////////////////////////////
  // serial multiply-accumulate, one tap per cycle
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (rx_valid) begin
      acc <= '0;
    end else if (busy) begin
      acc <= acc_next;
      if (tap_index == FIR_INDEX_WIDTH'(FIR_TAPS - 1))
        result <= filter_enable ? acc_next[FIR_SHIFT +: PCM_BITS]  // bits 17:10
                                : history[wr_ptr - 1'b1];          // bypass
    end
    if (have_credit && result_ready)
      tx_sample <= result;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr       <= '0;
      tap_index    <= '0;
      busy         <= 1'b0;
      result_ready <= 1'b0;
      credit_held  <= 1'b0;
      tx_valid     <= 1'b0;
    end else begin
      tx_valid <= 1'b0;
      // send only with a credit in hand, else keep the credit
      if (have_credit && result_ready) begin
        tx_valid     <= 1'b1;
        result_ready <= 1'b0;
        credit_held  <= 1'b0;
      end else if (credit) begin
        credit_held  <= 1'b1;  // never more than one
      end
      if (rx_valid) begin
        wr_ptr    <= wr_ptr + 1'b1;
        tap_index <= '0;
        busy      <= 1'b1;
      end else if (busy) begin
        tap_index <= tap_index + 1'b1;
        if (tap_index == FIR_INDEX_WIDTH'(FIR_TAPS - 1)) begin
          busy         <= 1'b0;
          result_ready <= 1'b1;  // after the send above, so a new result is never lost
        end
      end
    end
  end

endmodule

`default_nettype wire

/* source/audio_codec_top.sv */
`default_nettype none

module audio_codec_top
  import audio_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic button_up,
  input  logic button_down,
  input  logic filter_enable,
  input  logic sdata_in,
  output logic sdata_out,
  output logic sync,
  output logic codec_reset_b
);

  volume_t     volume;
  pcm_sample_t rx_sample, tx_sample;
  logic        rx_valid, tx_valid;
  logic        credit;

  codec_command_if cmd_bus ();

  ////////////////////////////////////////////////////////////
  // volume buttons and codec setup
  ////////////////////////////////////////////////////////////

  volume_control volume_ctrl (
    .clock       (clock),
    .reset       (reset),
    .button_up   (button_up),
    .button_down (button_down),
    .volume      (volume)
  );

  codec_command_sequencer sequencer (
    .clock  (clock),
    .reset  (reset),
    .volume (volume),
    .cmd    (cmd_bus.sequencer)
  );

  ////////////////////////////////////////////////////////////
  // serial link and sample path
  ////////////////////////////////////////////////////////////

  ac97_frame_link link (
    .clock         (clock),
    .reset         (reset),
    .sdata_in      (sdata_in),
    .sdata_out     (sdata_out),
    .sync          (sync),
    .codec_reset_b (codec_reset_b),
    .cmd           (cmd_bus.link),
    .rx_sample     (rx_sample),
    .rx_valid      (rx_valid),
    .credit        (credit),
    .tx_sample     (tx_sample),
    .tx_valid      (tx_valid)
  );

  fir_lowpass filter (  // mic back out to both channels
    .clock         (clock),
    .reset         (reset),
    .filter_enable (filter_enable),
    .rx_sample     (rx_sample),
    .rx_valid      (rx_valid),
    .credit        (credit),
    .tx_sample     (tx_sample),
    .tx_valid      (tx_valid)
  );

endmodule

`default_nettype wire

/* test/codec_model.sv */
`default_nettype none

// codec side of the serial link, same clock as the DUT
module codec_model
  import audio_pkg::*;
(
  input  logic        clock,
  input  logic        sync,
  input  logic        sdata_out,
  input  pcm_sample_t mic_sample,    // goes into slot 3 of every frame
  output logic        sdata_in,
  output int          frame_count,   // frames decoded so far
  output int          frame_cycles,  // length of the last frame
  output int          sync_cycles,   // sync high time of the last frame
  output logic [15:0] tag,
  output cmd_addr_t   cmd_address,
  output cmd_data_t   cmd_data,
  output slot_word_t  left_word,
  output slot_word_t  right_word
);

  timeunit 1ns;
  timeprecision 1ps;

  logic       frame_bits [FRAME_BITS];  // sdata_out by frame position
  bit_count_t pos;                      // frame position of this cycle
  bit_count_t offset;
  logic       aligned;                  // first sync edge seen
  logic       sync_prev;
  int         cycle_run;
  int         sync_run;
  slot_word_t word;

  // 20 bits from a frame position on, msb first
  function automatic slot_word_t slot_at(input bit_count_t first);
    slot_word_t w;
    w = '0;
    for (int i = 0; i < SLOT_BITS; i++)
      w = {w[SLOT_BITS-2:0], frame_bits[first + bit_count_t'(i)]};
    return w;
  endfunction

  initial begin
    sdata_in     <= 1'b0;
    frame_count  <= 0;
    frame_cycles <= 0;
    sync_cycles  <= 0;
    tag          <= '0;
    cmd_address  <= '0;
    cmd_data     <= '0;
    left_word    <= '0;
    right_word   <= '0;
    aligned   = 1'b0;
    sync_prev = 1'b0;
    pos       = '0;
    cycle_run = 0;
    sync_run  = 0;
    forever begin
      @(negedge clock);  // outputs settled here
      if (sync && !sync_prev) begin
        // sync rises on the last bit, so bits 0..254 are complete
        if (aligned) begin
          word = slot_at(8'd0);
          tag <= word[19:4];
          word = slot_at(SLOT_CMD_ADDR_FIRST);
          cmd_address <= word[19:12];   // left-justified
          word = slot_at(SLOT_CMD_DATA_FIRST);
          cmd_data     <= word[19:4];
          left_word    <= slot_at(SLOT_LEFT_FIRST);
          right_word   <= slot_at(SLOT_RIGHT_FIRST);
          frame_cycles <= cycle_run;
          sync_cycles  <= sync_run;
          frame_count  <= frame_count + 1;
        end
        aligned   = 1'b1;
        pos       = FRAME_LATCH_BIT;
        cycle_run = 1;
        sync_run  = 1;
      end else begin
        pos       = pos + 1'b1;  // wraps to bit 0
        cycle_run = cycle_run + 1;
        if (sync)
          sync_run = sync_run + 1;
      end
      sync_prev      = sync;
      frame_bits[pos] = sdata_out;
      // mic sample msb first in slot 3, rest of the line idle
      offset = pos - SLOT_LEFT_FIRST;
      if (aligned && pos >= SLOT_LEFT_FIRST && offset < 8'd8)
        sdata_in <= mic_sample[3'd7 - offset[2:0]];
      else
        sdata_in <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* test/audio_codec_tb.sv */
`default_nettype none

module audio_codec_tb
  import audio_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int HOLD_CYCLES = DEBOUNCE_CYCLES + 8;  // safely past the debounce
  localparam int COEFF_SUM   = 1022;                 // dc gain of the coefficient table
  localparam int PRESSES     = 64;
  localparam int TEST_FRAMES = 5 + 16 + 4 * 18 + 9 + 41;
  localparam int TIMEOUT_CYCLES = 2 * (16 + CODEC_RESET_CYCLES + FRAME_BITS * TEST_FRAMES
                                       + 2 * HOLD_CYCLES * PRESSES);  // double margin

  logic        clock, reset;
  logic        button_up, button_down, filter_enable;
  logic        sdata_in, sdata_out, sync, codec_reset_b;
  pcm_sample_t mic_sample;
  int          frame_count, frame_cycles, sync_cycles;
  logic [15:0] tag;
  cmd_addr_t   cmd_address;
  cmd_data_t   cmd_data;
  slot_word_t  left_word, right_word;

  int    errors = 0;
  int    checks = 0;
  int    seed = 96228;
  string test_name = "";

  audio_codec_top dut (
    .clock         (clock),
    .reset         (reset),
    .button_up     (button_up),
    .button_down   (button_down),
    .filter_enable (filter_enable),
    .sdata_in      (sdata_in),
    .sdata_out     (sdata_out),
    .sync          (sync),
    .codec_reset_b (codec_reset_b)
  );

  codec_model codec (
    .clock        (clock),
    .sync         (sync),
    .sdata_out    (sdata_out),
    .mic_sample   (mic_sample),
    .sdata_in     (sdata_in),
    .frame_count  (frame_count),
    .frame_cycles (frame_cycles),
    .sync_cycles  (sync_cycles),
    .tag          (tag),
    .cmd_address  (cmd_address),
    .cmd_data     (cmd_data),
    .left_word    (left_word),
    .right_word   (right_word)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;  // 20 ns
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clock);
    $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_sample(input string what, input pcm_sample_t expected,
                              input pcm_sample_t actual);
    checks++;
    if (actual !== expected) begin
      $display("[FAIL] %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic check_command(input string what, input cmd_addr_t exp_addr,
                               input cmd_data_t exp_data, input cmd_addr_t act_addr,
                               input cmd_data_t act_data);
    checks++;
    if (act_addr !== exp_addr || act_data !== exp_data) begin
      $display("[FAIL] %s %s: expected %h/%h, actual %h/%h", test_name, what,
               exp_addr, exp_data, act_addr, act_data);
      errors++;
    end
  endtask

  task automatic check_volume_word(input string what, input cmd_data_t expected,
                                   input cmd_data_t actual);
    checks++;
    if (actual !== expected) begin
      $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic check_bit(input string what, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      $display("[FAIL] %s %s: expected %b, actual %b", test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic check_count(input string what, input int expected, input int actual);
    checks++;
    if (actual != expected) begin
      $display("[FAIL] %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // returns on the falling edge after the count-th decoded frame
  task automatic wait_frames(input int count);
    int target;
    target = frame_count + count;
    while (frame_count != target)
      @(posedge clock);
    @(negedge clock);
  endtask

  task automatic press_button(input logic up, input int hold);
    if (up)
      button_up = 1'b1;
    else
      button_down = 1'b1;
    repeat (hold) @(negedge clock);
    button_up   = 1'b0;
    button_down = 1'b0;
    repeat (hold) @(negedge clock);  // released as long as held
  endtask

  // attenuation 31 - volume in both channel fields
  function automatic cmd_data_t headphone_word(input int volume);
    volume_t att;
    att = volume_t'(31 - volume);
    return {3'b000, att, 3'b000, att};
  endfunction

  task automatic expected_command(input int state, output cmd_addr_t addr,
                                  output cmd_data_t data);
    addr = REG_READ_ID;  // idle states read the id
    data = 16'h0000;
    case (state)
      3: begin
        addr = REG_HEADPHONE_VOL;
        data = headphone_word(VOLUME_RESET);
      end
      5: begin
        addr = REG_PCM_VOL;
        data = 16'h0808;
      end
      6: begin
        addr = REG_RECORD_SELECT;
        data = 16'h0000;  // mic both sides
      end
      7: begin
        addr = REG_RECORD_GAIN;
        data = 16'h0F0F;
      end
      9: begin
        addr = REG_MIC_GAIN;
        data = 16'h8048;
      end
      10: begin
        addr = REG_BEEP_VOL;
        data = 16'h0000;
      end
      11: begin
        addr = REG_GENERAL;
        data = 16'h8000;
      end
      default: ;
    endcase
  endtask

  task automatic confirm_volume(input string what, input int volume);
    bit found;
    found = 1'b0;
    wait_frames(1);  // frames from here on latch the settled volume
    for (int i = 0; i < 17 && !found; i++) begin
      wait_frames(1);
      if (cmd_address == REG_HEADPHONE_VOL) begin
        found = 1'b1;
        check_volume_word(what, headphone_word(volume), cmd_data);
      end
    end
    if (!found) begin
      $display("%s: no headphone volume command within 17 frames", test_name);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic reset_test();
    test_name = "reset";
    repeat (16) @(negedge clock);
    check_bit("sync", 1'b0, sync);
    check_bit("sdata_out", 1'b0, sdata_out);
    check_bit("codec_reset_b", 1'b0, codec_reset_b);
    reset = 1'b0;
    repeat (CODEC_RESET_CYCLES - 1) @(negedge clock);
    check_bit("codec_reset_b one cycle early", 1'b0, codec_reset_b);
    @(negedge clock);
    check_bit("codec_reset_b released", 1'b1, codec_reset_b);
  endtask

  task automatic frame_format_test();
    test_name = "frame_format";
    wait_frames(1);
    repeat (4) begin
      wait_frames(1);
      check_count("frame length", FRAME_BITS, frame_cycles);
      check_count("sync high cycles", 16, sync_cycles);
      check_bit("frame valid tag", 1'b1, tag[15]);
      check_bit("address valid tag", 1'b1, tag[14]);
      check_bit("left valid tag", 1'b1, tag[12]);
      check_bit("right valid tag", 1'b1, tag[11]);
    end
  endtask

  task automatic command_sequence_test();
    cmd_addr_t addrs[$];
    cmd_data_t datas[$];
    cmd_addr_t exp_addr;
    cmd_data_t exp_data;
    int        hp_frame;
    int        state;
    test_name = "command_sequence";
    hp_frame  = -1;
    for (int i = 0; i < 16; i++) begin
      wait_frames(1);
      addrs.push_back(cmd_address);
      datas.push_back(cmd_data);
      if (cmd_address == REG_HEADPHONE_VOL)
        hp_frame = i;  // state 3 anchors the rotation
    end
    if (hp_frame < 0) begin
      $display("%s: no headphone volume command in 16 frames", test_name);
      errors++;
    end else begin
      for (int i = 0; i < 16; i++) begin
        state = (3 + i - hp_frame + 16) % 16;
        expected_command(state, exp_addr, exp_data);
        check_command($sformatf("state %0d", state), exp_addr, exp_data, addrs[i], datas[i]);
      end
      check_volume_word("reset attenuation", 16'h1717, datas[hp_frame]);  // 23 = 31 - 8
    end
  endtask

  task automatic volume_button_test();
    test_name = "volume_buttons";
    press_button(1'b1, HOLD_CYCLES);          // 8 -> 9
    press_button(1'b1, DEBOUNCE_CYCLES / 2);  // too short, ignored
    confirm_volume("one press", 9);
    repeat (25) press_button(1'b1, HOLD_CYCLES);
    confirm_volume("up saturates", 31);
    press_button(1'b0, HOLD_CYCLES);          // 31 -> 30
    confirm_volume("one press down", 30);
    repeat (34) press_button(1'b0, HOLD_CYCLES);
    confirm_volume("down saturates", 0);
  endtask

  task automatic bypass_test();
    pcm_sample_t sample;
    test_name     = "bypass";
    filter_enable = 1'b0;
    wait_frames(1);
    repeat (4) begin
      sample     = pcm_sample_t'($random(seed));
      mic_sample = sample;  // frame N
      wait_frames(2);       // N+1 carries it
      check_sample("left slot", sample, pcm_sample_t'(left_word[19:12]));
      check_sample("right slot", sample, pcm_sample_t'(right_word[19:12]));
      check_bit("left low bits", 1'b0, |left_word[11:0]);
      check_bit("right low bits", 1'b0, |right_word[11:0]);
    end
  endtask

  task automatic filter_test();
    pcm_sample_t level;
    filter_acc_t scaled;
    test_name     = "lowpass";
    filter_enable = 1'b1;
    level         = pcm_sample_t'($random(seed));
    mic_sample    = level;
    scaled        = filter_acc_t'(int'(level) * COEFF_SUM);
    wait_frames(40);  // history full of the same level
    check_sample("left settled", pcm_sample_t'(scaled[FIR_SHIFT +: 8]),
                 pcm_sample_t'(left_word[19:12]));
    check_sample("right settled", pcm_sample_t'(scaled[FIR_SHIFT +: 8]),
                 pcm_sample_t'(right_word[19:12]));
    filter_enable = 1'b0;
  endtask

  initial begin
    reset         = 1'b1;
    button_up     = 1'b0;
    button_down   = 1'b0;
    filter_enable = 1'b0;
    mic_sample    = '0;
    reset_test();
    frame_format_test();
    command_sequence_test();
    volume_button_test();
    bypass_test();
    filter_test();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
source/audio_pkg.sv
source/codec_command_if.sv
source/button_debounce.sv
source/volume_control.sv
source/codec_command_sequencer.sv
source/ac97_frame_link.sv
source/fir_lowpass.sv
source/audio_codec_top.sv
test/codec_model.sv
test/audio_codec_tb.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --timescale 1ns/1ps \
  --top-module audio_codec_tb \
  -f project.f \
  --Mdir obj_dir \
  -o audio_codec_sim

./obj_dir/audio_codec_sim > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0
